//--- source/id_cfg.svh
// Decode stage configuration
// Data width, register address width and register count

`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// Data and address width
`define ID_XLEN 32

// Register address width
`define ID_REG_AW 5

// Architectural register count, x0 included
`define ID_NUM_REGS 32

`endif

//--- source/id_pkg.sv
// Decode stage types
// Opcodes, ALU operations, operand and target selects, and the
// instruction word seen through each RV32I format

package id_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPCODE_LUI    = 7'b0110111,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_JAL    = 7'b1101111,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_BRANCH = 7'b1100011,
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_OP     = 7'b0110011
  } opcode_e;

  // ALU operations, the last four are branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source, INCR is the constant 4
  typedef enum logic [1:0] {
    OP_B_REG,
    OP_B_IMM,
    OP_B_INCR
  } op_b_sel_e;

  // Base of the jump or branch target
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_PC,
    TGT_RS1
  } tgt_sel_e;

  ////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_type_t;

  // Branch offset bits are scattered, bit 0 is implicit
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_type_t;

  // One word, six views
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_word_u;

endpackage

//--- source/id_decoder.sv
// Decode stage 1
// Classifies the instruction word, checks its legality, extracts the
// sign-extended immediate and registers all decoded controls

`include "id_cfg.svh"

module id_decoder (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    instr_valid_i,
  input  id_pkg::instr_word_u     instr_i,
  input  logic [`ID_XLEN-1:0]     pc_i,
  output logic                    dec_valid_o,
  output logic                    dec_illegal_o,
  output id_pkg::alu_op_e         alu_op_o,
  output id_pkg::op_a_sel_e       op_a_sel_o,
  output id_pkg::op_b_sel_e       op_b_sel_o,
  output id_pkg::tgt_sel_e        tgt_sel_o,
  output logic [`ID_XLEN-1:0]     imm_o,
  output logic [`ID_REG_AW-1:0]   rs1_addr_o,
  output logic [`ID_REG_AW-1:0]   rs2_addr_o,
  output logic [`ID_REG_AW-1:0]   rd_addr_o,
  output logic                    rd_we_o,
  output logic                    lsu_req_o,
  output logic                    lsu_we_o,
  output logic                    branch_o,
  output logic                    jump_o,
  output logic [`ID_XLEN-1:0]     pc_o
);

  logic [`ID_XLEN-1:0] imm_i_type;
  logic [`ID_XLEN-1:0] imm_s_type;
  logic [`ID_XLEN-1:0] imm_b_type;
  logic [`ID_XLEN-1:0] imm_u_type;
  logic [`ID_XLEN-1:0] imm_j_type;
  logic [`ID_XLEN-1:0] imm_shamt;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                is_op;
  logic                funct7_zero;
  logic                funct7_alt;
  id_pkg::alu_op_e     alu_base;

  id_pkg::alu_op_e     alu_op_d;
  id_pkg::op_a_sel_e   op_a_sel_d;
  id_pkg::op_b_sel_e   op_b_sel_d;
  id_pkg::tgt_sel_e    tgt_sel_d;
  logic [`ID_XLEN-1:0] imm_d;
  logic                rd_we_d;
  logic                lsu_req_d;
  logic                lsu_we_d;
  logic                branch_d;
  logic                jump_d;
  logic                illegal_d;

  ////////////////////////////////////////
  // Immediate extraction
  ////////////////////////////////////////

  assign imm_i_type = {{(`ID_XLEN-12){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
  assign imm_s_type = {{(`ID_XLEN-12){instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
                       instr_i.s.imm_4_0};
  assign imm_b_type = {{(`ID_XLEN-13){instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                       instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
  assign imm_u_type = {instr_i.u.imm_31_12, 12'b0};
  assign imm_j_type = {{(`ID_XLEN-21){instr_i.j.imm_20}}, instr_i.j.imm_20,
                       instr_i.j.imm_19_12, instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
  // Shift amount sits in the rs2 field, zero-extended
  assign imm_shamt  = {{(`ID_XLEN-`ID_REG_AW){1'b0}}, instr_i.r.rs2};

  ////////////////////////////////////////
  // Opcode and function decode
  ////////////////////////////////////////

  assign funct3      = instr_i.r.funct3;
  assign funct7      = instr_i.r.funct7;
  assign is_op       = (instr_i.r.opcode == id_pkg::OPCODE_OP);
  assign funct7_zero = (funct7 == 7'h00);
  assign funct7_alt  = (funct7 == 7'h20);

  // ALU op shared by OP and OP-IMM
  always_comb begin
    case (funct3)
      // SUB only exists in the register form
      3'b000:  alu_base = (is_op && funct7[5]) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  alu_base = id_pkg::ALU_SLL;
      3'b010:  alu_base = id_pkg::ALU_SLT;
      3'b011:  alu_base = id_pkg::ALU_SLTU;
      3'b100:  alu_base = id_pkg::ALU_XOR;
      3'b101:  alu_base = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  alu_base = id_pkg::ALU_OR;
      default: alu_base = id_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    // Defaults describe a register-register op with no side effects
    alu_op_d   = id_pkg::ALU_ADD;
    op_a_sel_d = id_pkg::OP_A_REG;
    op_b_sel_d = id_pkg::OP_B_REG;
    tgt_sel_d  = id_pkg::TGT_NONE;
    imm_d      = '0;
    rd_we_d    = 1'b0;
    lsu_req_d  = 1'b0;
    lsu_we_d   = 1'b0;
    branch_d   = 1'b0;
    jump_d     = 1'b0;
    illegal_d  = 1'b0;

    case (instr_i.r.opcode)
      id_pkg::OPCODE_LUI: begin
        op_a_sel_d = id_pkg::OP_A_ZERO;
        op_b_sel_d = id_pkg::OP_B_IMM;
        imm_d      = imm_u_type;
        rd_we_d    = 1'b1;
      end
      id_pkg::OPCODE_AUIPC: begin
        op_a_sel_d = id_pkg::OP_A_PC;
        op_b_sel_d = id_pkg::OP_B_IMM;
        imm_d      = imm_u_type;
        rd_we_d    = 1'b1;
      end
      // Jumps compute the link address pc + 4 in the ALU
      id_pkg::OPCODE_JAL: begin
        op_a_sel_d = id_pkg::OP_A_PC;
        op_b_sel_d = id_pkg::OP_B_INCR;
        tgt_sel_d  = id_pkg::TGT_PC;
        imm_d      = imm_j_type;
        rd_we_d    = 1'b1;
        jump_d     = 1'b1;
      end
      id_pkg::OPCODE_JALR: begin
        op_a_sel_d = id_pkg::OP_A_PC;
        op_b_sel_d = id_pkg::OP_B_INCR;
        tgt_sel_d  = id_pkg::TGT_RS1;
        imm_d      = imm_i_type;
        rd_we_d    = 1'b1;
        jump_d     = 1'b1;
        illegal_d  = (funct3 != 3'b000);
      end
      id_pkg::OPCODE_BRANCH: begin
        tgt_sel_d = id_pkg::TGT_PC;
        imm_d     = imm_b_type;
        branch_d  = 1'b1;
        case (funct3)
          3'b000:  alu_op_d = id_pkg::ALU_EQ;
          3'b001:  alu_op_d = id_pkg::ALU_NE;
          3'b100:  alu_op_d = id_pkg::ALU_LT;
          3'b101:  alu_op_d = id_pkg::ALU_GE;
          default: illegal_d = 1'b1;
        endcase
      end
      // Word access only
      id_pkg::OPCODE_LOAD: begin
        op_b_sel_d = id_pkg::OP_B_IMM;
        imm_d      = imm_i_type;
        rd_we_d    = 1'b1;
        lsu_req_d  = 1'b1;
        illegal_d  = (funct3 != 3'b010);
      end
      id_pkg::OPCODE_STORE: begin
        op_b_sel_d = id_pkg::OP_B_IMM;
        imm_d      = imm_s_type;
        lsu_req_d  = 1'b1;
        lsu_we_d   = 1'b1;
        illegal_d  = (funct3 != 3'b010);
      end
      id_pkg::OPCODE_OP_IMM: begin
        op_b_sel_d = id_pkg::OP_B_IMM;
        alu_op_d   = alu_base;
        rd_we_d    = 1'b1;
        if (funct3[1:0] == 2'b01) begin
          // SLLI, SRLI and SRAI carry funct7 in the upper immediate
          imm_d     = imm_shamt;
          illegal_d = !(funct7_zero || (funct3 == 3'b101 && funct7_alt));
        end else begin
          imm_d = imm_i_type;
        end
      end
      id_pkg::OPCODE_OP: begin
        alu_op_d  = alu_base;
        rd_we_d   = 1'b1;
        illegal_d = !(funct7_zero ||
                      (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      default: illegal_d = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Stage 1 registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o   <= 1'b0;
      dec_illegal_o <= 1'b0;
    end else begin
      dec_valid_o   <= instr_valid_i;
      dec_illegal_o <= instr_valid_i & illegal_d;
    end
  end

  // Payload only moves with a strobe
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      alu_op_o   <= alu_op_d;
      op_a_sel_o <= op_a_sel_d;
      op_b_sel_o <= op_b_sel_d;
      tgt_sel_o  <= tgt_sel_d;
      imm_o      <= imm_d;
      rs1_addr_o <= instr_i.r.rs1;
      rs2_addr_o <= instr_i.r.rs2;
      rd_addr_o  <= instr_i.r.rd;
      rd_we_o    <= rd_we_d;
      lsu_req_o  <= lsu_req_d;
      lsu_we_o   <= lsu_we_d;
      branch_o   <= branch_d;
      jump_o     <= jump_d;
      pc_o       <= pc_i;
    end
  end

  // Fetch side never strobes an unknown word
  a_instr_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> !$isunknown(instr_i));

endmodule

//--- source/id_regfile.sv
// Integer register file
// 31 writable registers, x0 reads as zero, two combinational read
// ports and one write port

`include "id_cfg.svh"

module id_regfile (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`ID_REG_AW-1:0] raddr_a_i,
  input  logic [`ID_REG_AW-1:0] raddr_b_i,
  input  logic                  we_i,
  input  logic [`ID_REG_AW-1:0] waddr_i,
  input  logic [`ID_XLEN-1:0]   wdata_i,
  output logic [`ID_XLEN-1:0]   rdata_a_o,
  output logic [`ID_XLEN-1:0]   rdata_b_o
);

  // No storage behind x0
  logic [`ID_XLEN-1:0] rf_q [1:`ID_NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `ID_NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      // Writes to x0 fall away here
      rf_q[waddr_i] <= wdata_i;
    end
  end

  // No write-to-read bypass
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : rf_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : rf_q[raddr_b_i];

  // Writeback must name a register
  a_waddr_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown(waddr_i));

endmodule

//--- source/id_operand_stage.sv
// Decode stage 2
// Reads the source registers, selects the ALU operands, forms the
// jump or branch target and registers the issue to execute

`include "id_cfg.svh"

module id_operand_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  dec_valid_i,
  input  logic                  dec_illegal_i,
  input  id_pkg::alu_op_e       alu_op_i,
  input  id_pkg::op_a_sel_e     op_a_sel_i,
  input  id_pkg::op_b_sel_e     op_b_sel_i,
  input  id_pkg::tgt_sel_e      tgt_sel_i,
  input  logic [`ID_XLEN-1:0]   imm_i,
  input  logic [`ID_REG_AW-1:0] rs1_addr_i,
  input  logic [`ID_REG_AW-1:0] rs2_addr_i,
  input  logic [`ID_REG_AW-1:0] rd_addr_i,
  input  logic                  rd_we_i,
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  logic                  branch_i,
  input  logic                  jump_i,
  input  logic [`ID_XLEN-1:0]   pc_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_b_i,
  output logic [`ID_REG_AW-1:0] rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0] rf_raddr_b_o,
  output logic                  issue_valid_o,
  output logic                  illegal_o,
  output id_pkg::alu_op_e       alu_op_o,
  output logic [`ID_XLEN-1:0]   operand_a_o,
  output logic [`ID_XLEN-1:0]   operand_b_o,
  output logic [`ID_XLEN-1:0]   target_o,
  output logic [`ID_REG_AW-1:0] rd_addr_o,
  output logic                  rd_we_o,
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output logic [`ID_XLEN-1:0]   lsu_wdata_o,
  output logic                  branch_o,
  output logic                  jump_o
);

  logic                issue_d;
  logic [`ID_XLEN-1:0] operand_a_d;
  logic [`ID_XLEN-1:0] operand_b_d;
  logic [`ID_XLEN-1:0] tgt_sum;
  logic [`ID_XLEN-1:0] target_d;

  // Register reads happen while the instruction sits here
  assign rf_raddr_a_o = rs1_addr_i;
  assign rf_raddr_b_o = rs2_addr_i;

  // Illegal words never issue
  assign issue_d = dec_valid_i & ~dec_illegal_i;

  ////////////////////////////////////////
  // Operand and target muxes
  ////////////////////////////////////////

  always_comb begin
    case (op_a_sel_i)
      id_pkg::OP_A_PC:   operand_a_d = pc_i;
      id_pkg::OP_A_ZERO: operand_a_d = '0;
      default:           operand_a_d = rf_rdata_a_i;
    endcase
  end

  always_comb begin
    case (op_b_sel_i)
      id_pkg::OP_B_IMM:  operand_b_d = imm_i;
      id_pkg::OP_B_INCR: operand_b_d = `ID_XLEN'(4);
      default:           operand_b_d = rf_rdata_b_i;
    endcase
  end

  // One adder serves both pc and rs1 based targets
  assign tgt_sum = ((tgt_sel_i == id_pkg::TGT_RS1) ? rf_rdata_a_i : pc_i) + imm_i;

  always_comb begin
    case (tgt_sel_i)
      id_pkg::TGT_PC:  target_d = tgt_sum;
      // JALR drops bit 0
      id_pkg::TGT_RS1: target_d = {tgt_sum[`ID_XLEN-1:1], 1'b0};
      default:         target_d = '0;
    endcase
  end

  ////////////////////////////////////////
  // Issue registers
  ////////////////////////////////////////

  // Strobes and side-effect flags are qualified by issue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
      illegal_o     <= 1'b0;
      rd_we_o       <= 1'b0;
      lsu_req_o     <= 1'b0;
      lsu_we_o      <= 1'b0;
      branch_o      <= 1'b0;
      jump_o        <= 1'b0;
    end else begin
      issue_valid_o <= issue_d;
      illegal_o     <= dec_valid_i & dec_illegal_i;
      rd_we_o       <= issue_d & rd_we_i;
      lsu_req_o     <= issue_d & lsu_req_i;
      lsu_we_o      <= issue_d & lsu_we_i;
      branch_o      <= issue_d & branch_i;
      jump_o        <= issue_d & jump_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      alu_op_o    <= alu_op_i;
      operand_a_o <= operand_a_d;
      operand_b_o <= operand_b_d;
      target_o    <= target_d;
      rd_addr_o   <= rd_addr_i;
      lsu_wdata_o <= rf_rdata_b_i;
    end
  end

  // Stage 1 only flags a word that it strobes
  a_illegal_with_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_illegal_i |-> dec_valid_i);

endmodule

//--- source/id_top.sv
// Decode stage top level
// Stage 1 decoder, stage 2 operand select and the register file,
// two cycles from instruction strobe to issue

`include "id_cfg.svh"

module id_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Instruction strobe
  input  logic                  instr_valid_i,
  input  id_pkg::instr_word_u   instr_i,
  input  logic [`ID_XLEN-1:0]   pc_i,
  // Writeback port
  input  logic                  rf_we_i,
  input  logic [`ID_REG_AW-1:0] rf_waddr_i,
  input  logic [`ID_XLEN-1:0]   rf_wdata_i,
  // Issue to execute
  output logic                  issue_valid_o,
  output logic                  illegal_o,
  output id_pkg::alu_op_e       alu_op_o,
  output logic [`ID_XLEN-1:0]   operand_a_o,
  output logic [`ID_XLEN-1:0]   operand_b_o,
  output logic [`ID_XLEN-1:0]   target_o,
  output logic [`ID_REG_AW-1:0] rd_addr_o,
  output logic                  rd_we_o,
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output logic [`ID_XLEN-1:0]   lsu_wdata_o,
  output logic                  branch_o,
  output logic                  jump_o
);

  // Stage 1 to stage 2
  logic                  dec_valid;
  logic                  dec_illegal;
  id_pkg::alu_op_e       dec_alu_op;
  id_pkg::op_a_sel_e     dec_op_a_sel;
  id_pkg::op_b_sel_e     dec_op_b_sel;
  id_pkg::tgt_sel_e      dec_tgt_sel;
  logic [`ID_XLEN-1:0]   dec_imm;
  logic [`ID_REG_AW-1:0] dec_rs1_addr;
  logic [`ID_REG_AW-1:0] dec_rs2_addr;
  logic [`ID_REG_AW-1:0] dec_rd_addr;
  logic                  dec_rd_we;
  logic                  dec_lsu_req;
  logic                  dec_lsu_we;
  logic                  dec_branch;
  logic                  dec_jump;
  logic [`ID_XLEN-1:0]   dec_pc;

  // Register file read ports
  logic [`ID_REG_AW-1:0] rf_raddr_a;
  logic [`ID_REG_AW-1:0] rf_raddr_b;
  logic [`ID_XLEN-1:0]   rf_rdata_a;
  logic [`ID_XLEN-1:0]   rf_rdata_b;

  id_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .dec_valid_o   (dec_valid),
    .dec_illegal_o (dec_illegal),
    .alu_op_o      (dec_alu_op),
    .op_a_sel_o    (dec_op_a_sel),
    .op_b_sel_o    (dec_op_b_sel),
    .tgt_sel_o     (dec_tgt_sel),
    .imm_o         (dec_imm),
    .rs1_addr_o    (dec_rs1_addr),
    .rs2_addr_o    (dec_rs2_addr),
    .rd_addr_o     (dec_rd_addr),
    .rd_we_o       (dec_rd_we),
    .lsu_req_o     (dec_lsu_req),
    .lsu_we_o      (dec_lsu_we),
    .branch_o      (dec_branch),
    .jump_o        (dec_jump),
    .pc_o          (dec_pc)
  );

  id_operand_stage u_operand_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dec_valid_i   (dec_valid),
    .dec_illegal_i (dec_illegal),
    .alu_op_i      (dec_alu_op),
    .op_a_sel_i    (dec_op_a_sel),
    .op_b_sel_i    (dec_op_b_sel),
    .tgt_sel_i     (dec_tgt_sel),
    .imm_i         (dec_imm),
    .rs1_addr_i    (dec_rs1_addr),
    .rs2_addr_i    (dec_rs2_addr),
    .rd_addr_i     (dec_rd_addr),
    .rd_we_i       (dec_rd_we),
    .lsu_req_i     (dec_lsu_req),
    .lsu_we_i      (dec_lsu_we),
    .branch_i      (dec_branch),
    .jump_i        (dec_jump),
    .pc_i          (dec_pc),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .issue_valid_o (issue_valid_o),
    .illegal_o     (illegal_o),
    .alu_op_o      (alu_op_o),
    .operand_a_o   (operand_a_o),
    .operand_b_o   (operand_b_o),
    .target_o      (target_o),
    .rd_addr_o     (rd_addr_o),
    .rd_we_o       (rd_we_o),
    .lsu_req_o     (lsu_req_o),
    .lsu_we_o      (lsu_we_o),
    .lsu_wdata_o   (lsu_wdata_o),
    .branch_o      (branch_o),
    .jump_o        (jump_o)
  );

  id_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (rf_we_i),
    .waddr_i   (rf_waddr_i),
    .wdata_i   (rf_wdata_i),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

endmodule

//--- test/tb_id_vectors.svh
// Decode stage test vectors
// One row per instruction strobe, applied back to back

`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// Columns: instr, pc, illegal, alu_op, a_reg, a_val, b_reg, b_val, t_reg, t_val, rd, flags
// A reg column of -1 means the value column alone, else reg plus value
// Flags are {rd_we, lsu_req, lsu_we, branch, jump}

localparam int NUM_VECTORS = 23;

vec_t vectors [0:NUM_VECTORS-1] = '{
  // OP, register-register
  '{32'h002081B3, 'h0, 0, id_pkg::ALU_ADD, 1, 'h0, 2, 'h0, -1, 'h0, 3, 5'b10000},
  '{32'h407302B3, 'h0, 0, id_pkg::ALU_SUB, 6, 'h0, 7, 'h0, -1, 'h0, 5, 5'b10000},
  '{32'h40A4D433, 'h0, 0, id_pkg::ALU_SRA, 9, 'h0, 10, 'h0, -1, 'h0, 8, 5'b10000},
  '{32'h00D635B3, 'h0, 0, id_pkg::ALU_SLTU, 12, 'h0, 13, 'h0, -1, 'h0, 11, 5'b10000},
  // OP-IMM, negative and maximum I-immediates, then shifts
  '{32'hFFB08213, 'h0, 0, id_pkg::ALU_ADD, 1, 'h0, -1, 'hFFFFFFFB, -1, 'h0, 4, 5'b10000},
  '{32'h7FF7C713, 'h0, 0, id_pkg::ALU_XOR, 15, 'h0, -1, 'h7FF, -1, 'h0, 14, 5'b10000},
  '{32'h41F8D813, 'h0, 0, id_pkg::ALU_SRA, 17, 'h0, -1, 'h1F, -1, 'h0, 16, 5'b10000},
  '{32'h00399913, 'h0, 0, id_pkg::ALU_SLL, 19, 'h0, -1, 'h3, -1, 'h0, 18, 5'b10000},
  // Load and store addressing
  '{32'hFF0AAA03, 'h0, 0, id_pkg::ALU_ADD, 21, 'h0, -1, 'hFFFFFFF0, -1, 'h0, 20, 5'b11000},
  '{32'hFF6BA623, 'h0, 0, id_pkg::ALU_ADD, 23, 'h0, -1, 'hFFFFFFEC, -1, 'h0, 0, 5'b01100},
  // Upper immediates
  '{32'hABCDEC37, 'h0, 0, id_pkg::ALU_ADD, -1, 'h0, -1, 'hABCDE000, -1, 'h0, 24, 5'b10000},
  '{32'h80000C97, 'h1000, 0, id_pkg::ALU_ADD, -1, 'h1000, -1, 'h80000000, -1, 'h0, 25, 5'b10000},
  // Jumps link pc + 4
  '{32'hFF5FF0EF, 'h2000, 0, id_pkg::ALU_ADD, -1, 'h2000, -1, 'h4, -1, 'h1FF4, 1, 5'b10001},
  '{32'h259563EF, 'h10000, 0, id_pkg::ALU_ADD, -1, 'h10000, -1, 'h4, -1, 'h66A58, 7, 5'b10001},
  '{32'h005D0167, 'h3000, 0, id_pkg::ALU_ADD, -1, 'h3000, -1, 'h4, 26, 'h5, 2, 5'b10001},
  '{32'hFFFD81E7, 'h3004, 0, id_pkg::ALU_ADD, -1, 'h3004, -1, 'h4, 27, 'hFFFFFFFF, 3, 5'b10001},
  // Branches, BNE reads x0 on both ports
  '{32'hFE2088E3, 'h4000, 0, id_pkg::ALU_EQ, 1, 'h0, 2, 'h0, -1, 'h3FF0, 0, 5'b00010},
  '{32'h7FDE5F63, 'h5000, 0, id_pkg::ALU_GE, 28, 'h0, 29, 'h0, -1, 'h57FE, 0, 5'b00010},
  '{32'h00001463, 'h6000, 0, id_pkg::ALU_NE, 0, 'h0, 0, 'h0, -1, 'h6008, 0, 5'b00010},
  '{32'h81FF4063, 'h8000, 0, id_pkg::ALU_LT, 30, 'h0, 31, 'h0, -1, 'h7000, 0, 5'b00010},
  // Illegal words: bad opcode, MUL funct7, byte load
  '{32'h0000007F, 'h0, 1, id_pkg::ALU_ADD, -1, 'h0, -1, 'h0, -1, 'h0, 0, 5'b00000},
  '{32'h02208133, 'h0, 1, id_pkg::ALU_ADD, -1, 'h0, -1, 'h0, -1, 'h0, 0, 5'b00000},
  '{32'h00008083, 'h0, 1, id_pkg::ALU_ADD, -1, 'h0, -1, 'h0, -1, 'h0, 0, 5'b00000}
};

`endif

//--- test/tb_id_top.sv
// Decode stage testbench
// Preloads the register file, streams the vector table back to back
// and checks every issue or illegal strobe two cycles after its input

`include "id_cfg.svh"

module tb_id_top;

  localparam int IDLE_CYCLES    = 8;
  localparam int PRELOAD_CYCLES = `ID_NUM_REGS + 1;

  // One table row, see the vector file for the column meaning
  typedef struct {
    logic [`ID_XLEN-1:0] instr;
    logic [`ID_XLEN-1:0] pc;
    int                  illegal;
    id_pkg::alu_op_e     alu_op;
    int                  a_reg;
    logic [`ID_XLEN-1:0] a_val;
    int                  b_reg;
    logic [`ID_XLEN-1:0] b_val;
    int                  t_reg;
    logic [`ID_XLEN-1:0] t_val;
    int                  rd;
    logic [4:0]          flags;
  } vec_t;

  `include "tb_id_vectors.svh"

  // Reset, idle window, preload, table, then slack for the pipeline
  localparam int TIMEOUT_CYCLES = 2 + IDLE_CYCLES + PRELOAD_CYCLES + NUM_VECTORS + 20;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_valid_i;
  id_pkg::instr_word_u   instr_i;
  logic [`ID_XLEN-1:0]   pc_i;
  logic                  rf_we_i;
  logic [`ID_REG_AW-1:0] rf_waddr_i;
  logic [`ID_XLEN-1:0]   rf_wdata_i;
  logic                  issue_valid_o;
  logic                  illegal_o;
  id_pkg::alu_op_e       alu_op_o;
  logic [`ID_XLEN-1:0]   operand_a_o;
  logic [`ID_XLEN-1:0]   operand_b_o;
  logic [`ID_XLEN-1:0]   target_o;
  logic [`ID_REG_AW-1:0] rd_addr_o;
  logic                  rd_we_o;
  logic                  lsu_req_o;
  logic                  lsu_we_o;
  logic [`ID_XLEN-1:0]   lsu_wdata_o;
  logic                  branch_o;
  logic                  jump_o;

  // Model copy of the architectural registers
  logic [`ID_XLEN-1:0] model_rf [0:`ID_NUM_REGS-1];

  // Rows in flight and the negedge count at which each is due
  int row_idx;
  int pend_row [$];
  int pend_due [$];
  int neg_count   = 0;
  int cycle_count = 0;
  int errors      = 0;

  id_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rf_we_i       (rf_we_i),
    .rf_waddr_i    (rf_waddr_i),
    .rf_wdata_i    (rf_wdata_i),
    .issue_valid_o (issue_valid_o),
    .illegal_o     (illegal_o),
    .alu_op_o      (alu_op_o),
    .operand_a_o   (operand_a_o),
    .operand_b_o   (operand_b_o),
    .target_o      (target_o),
    .rd_addr_o     (rd_addr_o),
    .rd_we_o       (rd_we_o),
    .lsu_req_o     (lsu_req_o),
    .lsu_we_o      (lsu_we_o),
    .lsu_wdata_o   (lsu_wdata_o),
    .branch_o      (branch_o),
    .jump_o        (jump_o)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic check_value(string name, logic [`ID_XLEN-1:0] got, logic [`ID_XLEN-1:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  // Register value plus offset, or the offset alone
  function automatic logic [`ID_XLEN-1:0] resolve(int reg_idx, logic [`ID_XLEN-1:0] offset);
    logic [`ID_XLEN-1:0] base;
    base = (reg_idx >= 0) ? model_rf[reg_idx] : '0;
    return base + offset;
  endfunction

  task automatic check_row(int idx);
    vec_t                v;
    logic [`ID_XLEN-1:0] exp_target;
    v = vectors[idx];
    if (v.illegal != 0) begin
      // Trap only, nothing may be written back
      check_value("illegal_o", illegal_o, 1);
      check_value("issue_valid_o", issue_valid_o, 0);
      check_value("rd_we_o", rd_we_o, 0);
    end else begin
      exp_target = resolve(v.t_reg, v.t_val);
      // Register based targets are JALR, bit 0 cleared
      if (v.t_reg >= 0) begin
        exp_target[0] = 1'b0;
      end
      check_value("issue_valid_o", issue_valid_o, 1);
      check_value("illegal_o", illegal_o, 0);
      check_value("alu_op_o", alu_op_o, v.alu_op);
      check_value("operand_a_o", operand_a_o, resolve(v.a_reg, v.a_val));
      check_value("operand_b_o", operand_b_o, resolve(v.b_reg, v.b_val));
      check_value("target_o", target_o, exp_target);
      check_value("rd_we_o", rd_we_o, v.flags[4]);
      check_value("lsu_req_o", lsu_req_o, v.flags[3]);
      check_value("lsu_we_o", lsu_we_o, v.flags[2]);
      check_value("branch_o", branch_o, v.flags[1]);
      check_value("jump_o", jump_o, v.flags[0]);
      if (v.flags[4]) begin
        check_value("rd_addr_o", rd_addr_o, v.rd);
      end
      // Store data is the rs2 field's register
      if (v.flags[2]) begin
        check_value("lsu_wdata_o", lsu_wdata_o, model_rf[v.instr[24:20]]);
      end
    end
  endtask

  // Outputs settle after the rising edge, so sample on the falling one
  always @(negedge clk_i) begin
    neg_count++;
    if (instr_valid_i) begin
      pend_row.push_back(row_idx);
      pend_due.push_back(neg_count + 2);
    end
    if (pend_due.size() != 0 && pend_due[0] == neg_count) begin
      check_row(pend_row[0]);
      void'(pend_row.pop_front());
      void'(pend_due.pop_front());
    end else begin
      assert (!(issue_valid_o || illegal_o)) else begin
        errors++;
        $display("Time %0t: issue or illegal strobe with no instruction due", $time);
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      errors++;
      $display("Timeout after %0d cycles, %0d rows still in flight", cycle_count,
               pend_row.size());
      $display("Run aborted with %0d errors", errors);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // x0 is written too, the model keeps it at zero
  task automatic preload_regs();
    logic [`ID_XLEN-1:0] wval;
    for (int r = 0; r < `ID_NUM_REGS; r++) begin
      wval = $urandom();
      @(posedge clk_i);
      rf_we_i    <= 1'b1;
      rf_waddr_i <= r[`ID_REG_AW-1:0];
      rf_wdata_i <= wval;
      if (r != 0) begin
        model_rf[r] = wval;
      end
    end
    @(posedge clk_i);
    rf_we_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h6d08));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    rf_we_i       = 1'b0;
    rf_waddr_i    = '0;
    rf_wdata_i    = '0;
    row_idx       = 0;
    for (int r = 0; r < `ID_NUM_REGS; r++) begin
      model_rf[r] = '0;
    end

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Quiet window, the checker flags any stray strobe
    repeat (IDLE_CYCLES) @(posedge clk_i);
    preload_regs();

    // Rows go in back to back, one per cycle
    for (int i = 0; i < NUM_VECTORS; i++) begin
      @(posedge clk_i);
      instr_valid_i <= 1'b1;
      instr_i       <= vectors[i].instr;
      pc_i          <= vectors[i].pc;
      row_idx       <= i;
    end
    @(posedge clk_i);
    instr_valid_i <= 1'b0;

    while (pend_row.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);

    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+source
+incdir+test
source/id_pkg.sv
source/id_decoder.sv
source/id_regfile.sv
source/id_operand_stage.sv
source/id_top.sv
test/tb_id_top.sv
